// File: hw/emif_wr_pkg.sv
/*
 * DDR EMIF write bridge definitions
 * Word, line and address widths, plus the command FIFO entry, whose
 * payload holds either a burst header or one data word.
 */

`default_nettype none

package emif_wr_pkg;

    // user side
    localparam int word_width      = 32;
    localparam int word_addr_width = 25;
    localparam int len_width       = 8;

    // memory side, eight words per line
    localparam int words_per_line  = 8;
    localparam int line_width      = word_width * words_per_line;
    localparam int slot_width      = $clog2(words_per_line);
    localparam int line_addr_width = word_addr_width - slot_width;
    localparam int be_width        = line_width / 8;

    typedef logic [word_width-1:0] word_t;
    typedef logic [line_width-1:0] line_t;

    typedef struct packed {
        logic [len_width-1:0]       len;
        logic [word_addr_width-1:0] start_addr;
    } burst_hdr_t;

    // is_header selects which view of the payload is valid
    typedef union packed {
        burst_hdr_t hdr;
        struct packed {
            logic  pad;
            word_t data;
        } dat;
    } entry_payload_u;

    typedef struct packed {
        logic           is_header;
        entry_payload_u payload;
    } cmd_entry_t;

endpackage

`default_nettype wire

// File: hw/emif_wr_cmd_packer.sv
/*
 * Write command packer
 * Turns the start strobe and the user data beats into a stream of
 * FIFO entries, one header and then one entry per word.
 */

`timescale 1ns/1ps
`default_nettype none

module emif_wr_cmd_packer (
    input  logic                                 ddr_emif_clk,
    input  logic                                 ddr_emif_rst_n,
    input  logic                                 wr_start,
    input  logic [emif_wr_pkg::word_addr_width-1:0] wr_start_addr,
    input  logic [emif_wr_pkg::len_width-1:0]    wr_len,
    input  logic                                 wr_data_valid,
    input  emif_wr_pkg::word_t                   wr_data,
    output logic                                 wr_busy,
    output logic                                 push,
    output emif_wr_pkg::cmd_entry_t              push_entry
);

    import emif_wr_pkg::*;

    logic [len_width-1:0] beats_left;
    logic                 take_beat;

    // beats only count while a burst is open
    assign take_beat = wr_data_valid && wr_busy;

    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            push       <= 1'b0;
            wr_busy    <= 1'b0;
            beats_left <= '0;
        end else begin
            push <= 1'b0;
            if (wr_start) begin
                push       <= 1'b1;
                wr_busy    <= 1'b1;
                beats_left <= wr_len;
            end else if (take_beat) begin
                push       <= 1'b1;
                beats_left <= beats_left - 1'b1;
                // last beat closes the burst
                if (beats_left == len_width'(1)) begin
                    wr_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (wr_start) begin
            push_entry.is_header              <= 1'b1;
            push_entry.payload.hdr.len        <= wr_len;
            push_entry.payload.hdr.start_addr <= wr_start_addr;
        end else if (take_beat) begin
            push_entry.is_header        <= 1'b0;
            push_entry.payload.dat.pad  <= 1'b0;
            push_entry.payload.dat.data <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/emif_wr_cmd_fifo.sv
/*
 * Command FIFO
 * Single-clock first-word-fall-through buffer of command entries.
 */

`timescale 1ns/1ps
`default_nettype none

module emif_wr_cmd_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    ddr_emif_clk,
    input  logic                    ddr_emif_rst_n,
    input  logic                    push,
    input  emif_wr_pkg::cmd_entry_t push_entry,
    input  logic                    pop,
    output emif_wr_pkg::cmd_entry_t head_entry,
    output logic                    empty,
    output logic                    full
);

    import emif_wr_pkg::*;

    localparam int idx_width = $clog2(FIFO_DEPTH);

    cmd_entry_t           mem [FIFO_DEPTH];
    logic [idx_width:0]   wr_ptr;
    logic [idx_width:0]   rd_ptr;

    // extra pointer bit tells a full buffer from an empty one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[idx_width] != rd_ptr[idx_width]) &&
                   (wr_ptr[idx_width-1:0] == rd_ptr[idx_width-1:0]);

    assign head_entry = mem[rd_ptr[idx_width-1:0]];

    always_ff @(posedge ddr_emif_clk) begin
        if (push && !full) begin
            mem[wr_ptr[idx_width-1:0]] <= push_entry;
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/emif_wr_line_assembler.sv
/*
 * Line assembler
 * Pops command entries, packs words into a big-endian 256-bit line with
 * byte enables, and issues one memory write per line touched.
 */

`timescale 1ns/1ps
`default_nettype none

module emif_wr_line_assembler (
    input  logic                                    ddr_emif_clk,
    input  logic                                    ddr_emif_rst_n,
    input  emif_wr_pkg::cmd_entry_t                 head_entry,
    input  logic                                    empty,
    output logic                                    pop,
    output logic                                    ddr_emif_write,
    output logic [emif_wr_pkg::line_addr_width-1:0] ddr_emif_addr,
    output emif_wr_pkg::line_t                      ddr_emif_write_data,
    output logic [emif_wr_pkg::be_width-1:0]        ddr_emif_byte_enable
);

    import emif_wr_pkg::*;

    localparam logic [slot_width-1:0] last_slot = slot_width'(words_per_line - 1);

    logic [line_addr_width-1:0] line_addr;
    logic [slot_width-1:0]      slot;
    logic [len_width-1:0]       remaining;
    line_t                      stage_line;
    logic [be_width-1:0]        stage_be;

    logic                       take_hdr;
    logic                       take_data;
    logic                       line_done;
    logic [slot_width-1:0]      slot_pos;
    burst_hdr_t                 hdr;
    line_t                      line_fill;
    logic [be_width-1:0]        be_fill;

    // one entry per cycle, the FIFO never runs ahead of us
    assign pop = ~empty;

    always_comb begin
        take_hdr  = pop && head_entry.is_header;
        take_data = pop && !head_entry.is_header;
        hdr       = head_entry.payload.hdr;

        // slot 0 sits at the most significant end
        slot_pos  = last_slot - slot;
        line_fill = stage_line;
        line_fill[slot_pos*word_width +: word_width] = head_entry.payload.dat.data;
        be_fill   = stage_be;
        be_fill[slot_pos*4 +: 4] = 4'hf;

        line_done = take_data && ((slot == last_slot) || (remaining == len_width'(1)));
    end

    // burst tracking
    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            line_addr <= '0;
            slot      <= '0;
            remaining <= '0;
        end else if (take_hdr) begin
            line_addr <= hdr.start_addr[word_addr_width-1:slot_width];
            slot      <= hdr.start_addr[slot_width-1:0];
            remaining <= hdr.len;
        end else if (take_data) begin
            slot      <= slot + 1'b1;
            remaining <= remaining - 1'b1;
            if (line_done) begin
                line_addr <= line_addr + 1'b1;
            end
        end
    end

    // staging of the line being filled
    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            stage_line <= '0;
            stage_be   <= '0;
        end else if (line_done) begin
            stage_line <= '0;
            stage_be   <= '0;
        end else if (take_data) begin
            stage_line <= line_fill;
            stage_be   <= be_fill;
        end
    end

    // memory write, one cycle after the word that closes the line
    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            ddr_emif_write       <= 1'b0;
            ddr_emif_addr        <= '0;
            ddr_emif_write_data  <= '0;
            ddr_emif_byte_enable <= '0;
        end else begin
            ddr_emif_write <= line_done;
            if (line_done) begin
                ddr_emif_addr        <= line_addr;
                ddr_emif_write_data  <= line_fill;
                ddr_emif_byte_enable <= be_fill;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/emif_wr_bridge.sv
/*
 * DDR EMIF write bridge
 * Narrow user write port to the wide memory port, built from a command
 * packer, a command FIFO and a line assembler.
 */

`timescale 1ns/1ps
`default_nettype none

module emif_wr_bridge #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                    ddr_emif_clk,
    input  logic                                    ddr_emif_rst_n,
    input  logic                                    wr_start,
    input  logic [emif_wr_pkg::word_addr_width-1:0] wr_start_addr,
    input  logic [emif_wr_pkg::len_width-1:0]       wr_len,
    input  logic                                    wr_data_valid,
    input  emif_wr_pkg::word_t                      wr_data,
    output logic                                    wr_busy,
    output logic                                    ddr_emif_write,
    output logic [emif_wr_pkg::line_addr_width-1:0] ddr_emif_addr,
    output emif_wr_pkg::line_t                      ddr_emif_write_data,
    output logic [emif_wr_pkg::be_width-1:0]        ddr_emif_byte_enable
);

    import emif_wr_pkg::*;

    logic       push;
    cmd_entry_t push_entry;
    logic       pop;
    cmd_entry_t head_entry;
    logic       empty;

    emif_wr_cmd_packer packer_i (
        .ddr_emif_clk   (ddr_emif_clk),
        .ddr_emif_rst_n (ddr_emif_rst_n),
        .wr_start       (wr_start),
        .wr_start_addr  (wr_start_addr),
        .wr_len         (wr_len),
        .wr_data_valid  (wr_data_valid),
        .wr_data        (wr_data),
        .wr_busy        (wr_busy),
        .push           (push),
        .push_entry     (push_entry)
    );

    // push and pop rates match so the FIFO never fills
    emif_wr_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .ddr_emif_clk   (ddr_emif_clk),
        .ddr_emif_rst_n (ddr_emif_rst_n),
        .push           (push),
        .push_entry     (push_entry),
        .pop            (pop),
        .head_entry     (head_entry),
        .empty          (empty),
        .full           ()
    );

    emif_wr_line_assembler assembler_i (
        .ddr_emif_clk         (ddr_emif_clk),
        .ddr_emif_rst_n       (ddr_emif_rst_n),
        .head_entry           (head_entry),
        .empty                (empty),
        .pop                  (pop),
        .ddr_emif_write       (ddr_emif_write),
        .ddr_emif_addr        (ddr_emif_addr),
        .ddr_emif_write_data  (ddr_emif_write_data),
        .ddr_emif_byte_enable (ddr_emif_byte_enable)
    );

endmodule

`default_nettype wire

// File: tests/tb_emif_wr_bridge.sv
/*
 * Testbench for the DDR EMIF write bridge
 * Directed and seeded random bursts, checked line by line against a
 * model of the expected memory writes.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_emif_wr_bridge;

    import emif_wr_pkg::*;

    localparam int num_bursts = 203;
    localparam int max_cycles = num_bursts * (255 * 4 + 20) + 200;

    logic                       ddr_emif_clk;
    logic                       ddr_emif_rst_n;
    logic                       wr_start;
    logic [word_addr_width-1:0] wr_start_addr;
    logic [len_width-1:0]       wr_len;
    logic                       wr_data_valid;
    word_t                      wr_data;
    logic                       wr_busy;
    logic                       ddr_emif_write;
    logic [line_addr_width-1:0] ddr_emif_addr;
    line_t                      ddr_emif_write_data;
    logic [be_width-1:0]        ddr_emif_byte_enable;

    // expected line writes, oldest first
    logic [line_addr_width-1:0] exp_addr_q[$];
    logic [be_width-1:0]        exp_be_q[$];
    line_t                      exp_data_q[$];
    word_t                      burst_words[$];

    int errors;
    int writes_checked;
    int cycle_count;
    int seed_val;

    emif_wr_bridge #(
        .FIFO_DEPTH (16)
    ) dut_i (
        .ddr_emif_clk         (ddr_emif_clk),
        .ddr_emif_rst_n       (ddr_emif_rst_n),
        .wr_start             (wr_start),
        .wr_start_addr        (wr_start_addr),
        .wr_len               (wr_len),
        .wr_data_valid        (wr_data_valid),
        .wr_data              (wr_data),
        .wr_busy              (wr_busy),
        .ddr_emif_write       (ddr_emif_write),
        .ddr_emif_addr        (ddr_emif_addr),
        .ddr_emif_write_data  (ddr_emif_write_data),
        .ddr_emif_byte_enable (ddr_emif_byte_enable)
    );

    initial begin
        ddr_emif_clk = 1'b0;
        forever #2 ddr_emif_clk = ~ddr_emif_clk;
    end

    always @(posedge ddr_emif_clk) begin
        cycle_count++;
    end

    // expand four enable bits per word into a bit mask
    function automatic line_t enabled_bits(input logic [be_width-1:0] be);
        line_t mask;
        mask = '0;
        for (int i = 0; i < be_width; i++) begin
            mask[i*8 +: 8] = be[i] ? 8'hff : 8'h00;
        end
        return mask;
    endfunction

    // word k goes to word address addr + k, slot 0 at the top of the line
    task automatic predict_writes(input logic [word_addr_width-1:0] addr, input int len);
        logic [word_addr_width-1:0] a;
        int                         pos;
        line_t                      line;
        logic [be_width-1:0]        be;
        line = '0;
        be   = '0;
        for (int k = 0; k < len; k++) begin
            a   = addr + word_addr_width'(k);
            pos = words_per_line - 1 - int'(a[slot_width-1:0]);
            line[pos*word_width +: word_width] = burst_words[k];
            be[pos*4 +: 4] = 4'hf;
            if (a[slot_width-1:0] == slot_width'(words_per_line - 1) || k == len - 1) begin
                exp_addr_q.push_back(a[word_addr_width-1:slot_width]);
                exp_be_q.push_back(be);
                exp_data_q.push_back(line);
                line = '0;
                be   = '0;
            end
        end
    endtask

    task automatic compare_write();
        logic [line_addr_width-1:0] e_addr;
        logic [be_width-1:0]        e_be;
        line_t                      e_data;
        line_t                      mask;
        assert (exp_addr_q.size() != 0) else begin
            errors++;
            $display("unexpected memory write to line %h with no burst words pending",
                     ddr_emif_addr);
        end
        if (exp_addr_q.size() != 0) begin
            e_addr = exp_addr_q.pop_front();
            e_be   = exp_be_q.pop_front();
            e_data = exp_data_q.pop_front();
            mask   = enabled_bits(e_be);
            assert (ddr_emif_addr === e_addr) else begin
                errors++;
                $display("[FAIL] ddr_emif_addr expected %h actual %h", e_addr, ddr_emif_addr);
            end
            assert (ddr_emif_byte_enable === e_be) else begin
                errors++;
                $display("[FAIL] ddr_emif_byte_enable expected %h actual %h",
                         e_be, ddr_emif_byte_enable);
            end
            assert ((ddr_emif_write_data & mask) === (e_data & mask)) else begin
                errors++;
                $display("[FAIL] ddr_emif_write_data expected %h actual %h",
                         e_data & mask, ddr_emif_write_data & mask);
            end
            writes_checked++;
        end
    endtask

    // outputs settle after the rising edge, sample on the falling one
    always @(negedge ddr_emif_clk) begin
        if (ddr_emif_rst_n === 1'b1 && ddr_emif_write === 1'b1) begin
            compare_write();
        end
    end

    task automatic expect_idle();
        assert (ddr_emif_write === 1'b0) else begin
            errors++;
            $display("[FAIL] ddr_emif_write expected %h actual %h", 1'b0, ddr_emif_write);
        end
        assert (wr_busy === 1'b0) else begin
            errors++;
            $display("[FAIL] wr_busy expected %h actual %h", 1'b0, wr_busy);
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic send_burst(input logic [word_addr_width-1:0] addr, input int len,
                              input int max_gap);
        int gap;
        burst_words = {};
        for (int k = 0; k < len; k++) begin
            burst_words.push_back($urandom);
        end
        predict_writes(addr, len);
        while (wr_busy !== 1'b0) begin
            @(posedge ddr_emif_clk);
            #1;
        end
        wr_start      = 1'b1;
        wr_start_addr = addr;
        wr_len        = len_width'(len);
        @(posedge ddr_emif_clk);
        #1;
        wr_start = 1'b0;
        for (int k = 0; k < len; k++) begin
            assert (wr_busy === 1'b1) else begin
                errors++;
                $display("[FAIL] wr_busy expected %h actual %h", 1'b1, wr_busy);
            end
            wr_data_valid = 1'b1;
            wr_data       = burst_words[k];
            @(posedge ddr_emif_clk);
            #1;
            wr_data_valid = 1'b0;
            gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
            repeat (gap) begin
                @(posedge ddr_emif_clk);
                #1;
            end
        end
        assert (wr_busy === 1'b0) else begin
            errors++;
            $display("[FAIL] wr_busy expected %h actual %h", 1'b0, wr_busy);
        end
    endtask

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge ddr_emif_clk);
        end
        $display("timeout after %0d cycles, the bridge stopped making progress", cycle_count);
        $display("errors: %0d, writes checked: %0d", errors + 1, writes_checked);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int drain;
        seed_val       = $urandom(32'h3943);
        errors         = 0;
        writes_checked = 0;
        cycle_count    = 0;
        ddr_emif_rst_n = 1'b0;
        wr_start       = 1'b0;
        wr_start_addr  = '0;
        wr_len         = '0;
        wr_data_valid  = 1'b0;
        wr_data        = '0;

        repeat (4) begin
            @(posedge ddr_emif_clk);
            #1;
            expect_idle();
        end
        ddr_emif_rst_n = 1'b1;
        repeat (10) begin
            @(posedge ddr_emif_clk);
            #1;
            expect_idle();
        end

        // full aligned line, short unaligned line, then one spanning five lines
        send_burst(25'h0012340, 8, 0);
        send_burst(25'h0005673, 3, 2);
        send_burst(25'h00abc05, 30, 1);

        for (int b = 0; b < 200; b++) begin
            send_burst(word_addr_width'($urandom), $urandom_range(40, 1), 3);
        end

        drain = 0;
        while (exp_addr_q.size() != 0 && drain < 50) begin
            @(posedge ddr_emif_clk);
            #1;
            drain++;
        end
        repeat (10) begin
            @(posedge ddr_emif_clk);
            #1;
            expect_idle();
        end
        assert (exp_addr_q.size() == 0) else begin
            errors++;
            $display("memory writes missing, %0d expected line writes never came",
                     exp_addr_q.size());
        end

        $display("errors: %0d, writes checked: %0d", errors, writes_checked);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: emif_wr_bridge.f
hw/emif_wr_pkg.sv
hw/emif_wr_cmd_packer.sv
hw/emif_wr_cmd_fifo.sv
hw/emif_wr_line_assembler.sv
hw/emif_wr_bridge.sv
tests/tb_emif_wr_bridge.sv
